//--- source/isa_pkg.sv
package isa_pkg;

	localparam int pc_bits = 64;

	// Instructions are word aligned, so the two lowest address bits carry no information.
	localparam int index_lsb = 2;

	typedef logic [pc_bits-1:0] pc_t;

endpackage

//--- source/predictor_pkg.sv
package predictor_pkg;

	localparam int index_bits = 4;
	localparam int history_entries = 16;              // One entry per value of the index.

	// Number of outcomes that each history entry remembers.
	localparam int history_bits = 4;

	localparam int counter_entries = 16;              // One counter per history pattern.

	typedef logic [index_bits-1:0] index_t;

	typedef logic [history_bits-1:0] history_t;       // Newest outcome sits in bit 0.

	// Values 0 and 1 predict not taken, values 2 and 3 predict taken.
	typedef logic [1:0] counter_t;

	localparam counter_t counter_reset = 2'd0;        // Strongly not taken.

endpackage

//--- source/pht_if.sv
interface pht_if;
	import predictor_pkg::*;

	logic lookup1_valid;
	history_t lookup1_history;
	logic lookup2_valid;
	history_t lookup2_history;

	logic train1_valid;
	logic train1_taken;
	history_t train1_history;                         // Pattern that selects the counter to train.
	logic train2_valid;
	logic train2_taken;
	history_t train2_history;

	modport history_side (
		output lookup1_valid, lookup1_history,
		output lookup2_valid, lookup2_history,
		output train1_valid, train1_taken, train1_history,
		output train2_valid, train2_taken, train2_history
	);

	modport pattern_side (
		input lookup1_valid, lookup1_history,
		input lookup2_valid, lookup2_history,
		input train1_valid, train1_taken, train1_history,
		input train2_valid, train2_taken, train2_history
	);

endinterface

//--- source/local_history_table.sv
module local_history_table (
	input logic clock,
	input logic reset,
	input logic enable,
	input isa_pkg::pc_t inst1_pc,
	input logic inst1_valid,
	input isa_pkg::pc_t inst2_pc,
	input logic inst2_valid,
	input isa_pkg::pc_t branch1_pc,
	input logic branch1_taken,
	input logic branch1_valid,
	input isa_pkg::pc_t branch2_pc,
	input logic branch2_taken,
	input logic branch2_valid,
	pht_if.history_side pht
);
	import isa_pkg::*;
	import predictor_pkg::*;

	history_t history [history_entries];
	history_t history_next [history_entries];
	index_t inst1_index;
	index_t inst2_index;
	index_t branch1_index;
	index_t branch2_index;
	history_t branch1_history;
	history_t branch1_updated;
	history_t branch2_history;
	history_t branch2_updated;
	logic same_entry;

	function automatic index_t table_index(pc_t pc);
		return pc[index_lsb +: index_bits];
	endfunction

	function automatic history_t shift_in(history_t old_history, logic taken);
		return {old_history[history_bits-2:0], taken};
	endfunction

	assign inst1_index = table_index(inst1_pc);
	assign inst2_index = table_index(inst2_pc);
	assign branch1_index = table_index(branch1_pc);
	assign branch2_index = table_index(branch2_pc);

	assign pht.lookup1_valid = inst1_valid && enable && !reset;    // No predictions during reset.
	assign pht.lookup2_valid = inst2_valid && enable && !reset;
	assign pht.lookup1_history = pht.lookup1_valid ? history[inst1_index] : '0;
	assign pht.lookup2_history = pht.lookup2_valid ? history[inst2_index] : '0;

	// Slot 2 sees the entry as slot 1 left it when both resolve into the same entry.
	assign same_entry = branch1_valid && branch2_valid && (branch1_index == branch2_index);
	assign branch1_history = history[branch1_index];
	assign branch1_updated = shift_in(branch1_history, branch1_taken);
	assign branch2_history = same_entry ? branch1_updated : history[branch2_index];
	assign branch2_updated = shift_in(branch2_history, branch2_taken);

	assign pht.train1_valid = branch1_valid;
	assign pht.train1_taken = branch1_taken;
	assign pht.train1_history = branch1_history;
	assign pht.train2_valid = branch2_valid;
	assign pht.train2_taken = branch2_taken;
	assign pht.train2_history = branch2_history;

	always_comb begin
		history_next = history;
		if (branch1_valid) begin
			history_next[branch1_index] = branch1_updated;
		end
		if (branch2_valid) begin
			history_next[branch2_index] = branch2_updated;    // Already holds both shifts if shared.
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < history_entries; i++) begin
				history[i] <= '0;
			end
		end else begin
			history <= history_next;
		end
	end

	// An unknown address on a valid strobe would spread X through a whole table entry.
	assert property (@(posedge clock) disable iff (reset)
		(inst1_valid |-> !$isunknown(inst1_pc)) and (inst2_valid |-> !$isunknown(inst2_pc)))
		else $error("Valid fetch strobe with unknown address.");

	assert property (@(posedge clock) disable iff (reset)
		(branch1_valid |-> !$isunknown(branch1_pc)) and (branch2_valid |-> !$isunknown(branch2_pc)))
		else $error("Valid resolve strobe with unknown address.");

endmodule

//--- source/pattern_table.sv
module pattern_table (
	input logic clock,
	input logic reset,
	pht_if.pattern_side pht,
	output logic inst1_predict,
	output logic inst1_predict_valid,
	output logic inst2_predict,
	output logic inst2_predict_valid
);
	import predictor_pkg::*;

	counter_t [counter_entries-1:0] counters;
	counter_t [counter_entries-1:0] counters_next;
	counter_t train1_counter;
	counter_t train1_stepped;
	counter_t train2_counter;
	counter_t train2_stepped;
	logic same_counter;

	function automatic counter_t saturate_step(counter_t count, logic taken);
		counter_t result;
		result = count;
		if (taken && count != '1) begin
			result = count + 2'd1;
		end else if (!taken && count != '0) begin
			result = count - 2'd1;
		end
		return result;
	endfunction

	// The upper counter bit is the direction.
	assign inst1_predict_valid = pht.lookup1_valid;
	assign inst2_predict_valid = pht.lookup2_valid;
	assign inst1_predict = pht.lookup1_valid && counters[pht.lookup1_history][1];
	assign inst2_predict = pht.lookup2_valid && counters[pht.lookup2_history][1];

	assign same_counter = pht.train1_valid && pht.train2_valid &&
		(pht.train1_history == pht.train2_history);
	assign train1_counter = counters[pht.train1_history];
	assign train1_stepped = saturate_step(train1_counter, pht.train1_taken);
	assign train2_counter = same_counter ? train1_stepped : counters[pht.train2_history];
	assign train2_stepped = saturate_step(train2_counter, pht.train2_taken);

	always_comb begin
		counters_next = counters;
		if (pht.train1_valid) begin
			counters_next[pht.train1_history] = train1_stepped;
		end
		if (pht.train2_valid) begin
			counters_next[pht.train2_history] = train2_stepped;  // Two steps on a shared counter.
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			counters <= {counter_entries{counter_reset}};
		end else begin
			counters <= counters_next;
		end
	end

	// Downstream fetch logic may sample predict without looking at predict_valid.
	assert property (@(posedge clock)
		(!inst1_predict_valid |-> !inst1_predict) and (!inst2_predict_valid |-> !inst2_predict))
		else $error("Prediction raised without predict_valid.");

	// Histories from the other table index this array, so an X here means X training upstream.
	assert property (@(posedge clock) disable iff (reset) !$isunknown(counters))
		else $error("Pattern counters hold unknown values after reset.");

endmodule

//--- source/local_predictor.sv
module local_predictor (
	input logic clock,
	input logic reset,
	input logic enable,

	input isa_pkg::pc_t inst1_pc,
	input logic inst1_valid,
	input isa_pkg::pc_t inst2_pc,
	input logic inst2_valid,

	input isa_pkg::pc_t branch1_pc,
	input logic branch1_taken,                        // Resolved direction of the older branch.
	input logic branch1_valid,
	input isa_pkg::pc_t branch2_pc,
	input logic branch2_taken,
	input logic branch2_valid,

	output logic inst1_predict,
	output logic inst1_predict_valid,
	output logic inst2_predict,
	output logic inst2_predict_valid
);

	pht_if pht ();

	local_history_table history_table (
		.clock          (clock),
		.reset          (reset),
		.enable         (enable),
		.inst1_pc       (inst1_pc),
		.inst1_valid    (inst1_valid),
		.inst2_pc       (inst2_pc),
		.inst2_valid    (inst2_valid),
		.branch1_pc     (branch1_pc),
		.branch1_taken  (branch1_taken),
		.branch1_valid  (branch1_valid),
		.branch2_pc     (branch2_pc),
		.branch2_taken  (branch2_taken),
		.branch2_valid  (branch2_valid),
		.pht            (pht.history_side)
	);

	// Counters are indexed by the histories that the table above selects.
	pattern_table counter_table (
		.clock                (clock),
		.reset                (reset),
		.pht                  (pht.pattern_side),
		.inst1_predict        (inst1_predict),
		.inst1_predict_valid  (inst1_predict_valid),
		.inst2_predict        (inst2_predict),
		.inst2_predict_valid  (inst2_predict_valid)
	);

endmodule

//--- dv/clock_gen.sv
module clock_gen (
	output logic clock,
	output logic reset
);

	localparam int half_period = 10;
	localparam int reset_cycles = 10;

	initial begin
		clock = 1'b0;
		forever #(half_period) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;                                // Released on the edge, like any other input.
	end

endmodule

//--- dv/tb_local_predictor.sv
module tb_local_predictor;
	import isa_pkg::*;
	import predictor_pkg::*;

	localparam int reset_cycles = 10;
	localparam int random_cycles = 300;
	localparam int test_cycles = 20 + 14 + 24 + 32 + 12 + random_cycles + 2;
	localparam int watchdog_time = (reset_cycles + test_cycles + 100) * 20;

	logic clock;
	logic reset;
	logic enable;
	pc_t inst1_pc;
	logic inst1_valid;
	pc_t inst2_pc;
	logic inst2_valid;
	pc_t branch1_pc;
	logic branch1_taken;
	logic branch1_valid;
	pc_t branch2_pc;
	logic branch2_taken;
	logic branch2_valid;
	logic inst1_predict;
	logic inst1_predict_valid;
	logic inst2_predict;
	logic inst2_predict_valid;

	history_t model_history [history_entries];
	counter_t model_counter [counter_entries];
	logic [31:0] lfsr_state = 32'd86467;

	clock_gen clock_gen_i (.clock(clock), .reset(reset));

	local_predictor dut_i (.*);

	function automatic logic random_bit();
		logic feedback;
		feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], feedback};
		return feedback;
	endfunction

	function automatic logic [63:0] random_bits(int count);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[62:0], random_bit()};
		end
		return value;
	endfunction

	function automatic pc_t random_pc();
		logic [63:0] bits;
		bits = random_bits(10);                       // Six tag bits over a four bit index.
		return {52'd0, bits[9:0], 2'b00};
	endfunction

	// Returns {predict_valid, predict} for one fetch slot.
	function automatic logic [1:0] expected_prediction(pc_t pc, logic valid, logic en,
			logic in_reset);
		history_t pattern;
		if (in_reset !== 1'b0 || !(valid && en)) begin
			return 2'b00;
		end
		pattern = model_history[pc[index_lsb +: index_bits]];
		return {1'b1, model_counter[pattern] >= 2'd2};
	endfunction

	function automatic void model_train(pc_t pc, logic taken);
		index_t entry;
		history_t pattern;
		entry = pc[index_lsb +: index_bits];
		pattern = model_history[entry];
		if (taken && model_counter[pattern] < 2'd3) begin
			model_counter[pattern] = model_counter[pattern] + 2'd1;
		end else if (!taken && model_counter[pattern] > 2'd0) begin
			model_counter[pattern] = model_counter[pattern] - 2'd1;
		end
		model_history[entry] = {pattern[history_bits-2:0], taken};
	endfunction

	task automatic check(string name, logic [63:0] actual, logic [63:0] expected);
		if (actual !== expected) begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Something failed");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	task automatic set_fetch(pc_t pc1, logic valid1, pc_t pc2, logic valid2);
		inst1_pc <= pc1;
		inst1_valid <= valid1;
		inst2_pc <= pc2;
		inst2_valid <= valid2;
	endtask

	task automatic set_resolve(pc_t pc1, logic taken1, logic valid1,
			pc_t pc2, logic taken2, logic valid2);
		branch1_pc <= pc1;
		branch1_taken <= taken1;
		branch1_valid <= valid1;
		branch2_pc <= pc2;
		branch2_taken <= taken2;
		branch2_valid <= valid2;
	endtask

	task automatic next_cycle();
		@(posedge clock);
	endtask

	task automatic lookups_after_reset();
		enable <= 1'b1;
		for (int n = 0; n < 20; n++) begin
			set_fetch(random_pc(), 1'b1, random_pc(), 1'b1);
			set_resolve('0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
			next_cycle();
		end
	endtask

	task automatic training_while_disabled(pc_t pc);
		enable <= 1'b0;
		for (int n = 0; n < 10; n++) begin
			set_fetch(pc, 1'b1, pc + 64'h4, 1'b1);
			set_resolve(pc, 1'b1, 1'b1, pc, 1'b1, 1'b1);
			next_cycle();
		end
		enable <= 1'b1;                               // The trained entry should now predict taken.
		set_resolve('0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
		repeat (4) next_cycle();
	endtask

	task automatic saturate_and_return(pc_t pc);
		for (int n = 0; n < 24; n++) begin
			set_fetch(pc, 1'b1, pc, 1'b1);
			set_resolve(pc, n < 12, 1'b1, '0, 1'b0, 1'b0);
			next_cycle();
		end
	endtask

	task automatic alternating_branch(pc_t pc);
		for (int n = 0; n < 32; n++) begin
			set_fetch(pc, 1'b1, pc + 64'h40, 1'b1);
			set_resolve(pc, n[0], 1'b1, '0, 1'b0, 1'b0);
			next_cycle();
		end
	endtask

	// Both slots in one entry first, then in two different entries.
	task automatic dual_resolve(pc_t pc, pc_t other1, pc_t other2);
		for (int n = 0; n < 6; n++) begin
			set_fetch(pc, 1'b1, pc + 64'h40, 1'b1);
			set_resolve(pc, n[0], 1'b1, pc + 64'h40, !n[1], 1'b1);
			next_cycle();
		end
		for (int n = 0; n < 6; n++) begin
			set_fetch(other1, 1'b1, other2, 1'b1);
			set_resolve(other1, 1'b1, 1'b1, other2, n[0], 1'b1);
			next_cycle();
		end
	endtask

	task automatic random_traffic();
		for (int n = 0; n < random_cycles; n++) begin
			enable <= (random_bits(3) != 0);
			set_fetch(random_pc(), random_bit(), random_pc(), random_bit());
			set_resolve(random_pc(), random_bit(), random_bit(),
				random_pc(), random_bit(), random_bit());
			next_cycle();
		end
	endtask

	// The model sees the same edge as the DUT, slot 1 before slot 2.
	always @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < history_entries; i++) begin
				model_history[i] = '0;
			end
			for (int i = 0; i < counter_entries; i++) begin
				model_counter[i] = counter_reset;
			end
		end else begin
			if (branch1_valid) begin
				model_train(branch1_pc, branch1_taken);
			end
			if (branch2_valid) begin
				model_train(branch2_pc, branch2_taken);
			end
		end
	end

	// Comparison starts once the clock runs, so the first edge out of X is skipped.
	initial begin
		logic [1:0] slot1;
		logic [1:0] slot2;
		@(posedge clock);
		forever begin
			@(negedge clock);
			slot1 = expected_prediction(inst1_pc, inst1_valid, enable, reset);
			slot2 = expected_prediction(inst2_pc, inst2_valid, enable, reset);
			check("inst1_predict_valid", inst1_predict_valid, slot1[1]);
			check("inst1_predict", inst1_predict, slot1[0]);
			check("inst2_predict_valid", inst2_predict_valid, slot2[1]);
			check("inst2_predict", inst2_predict, slot2[0]);
		end
	end

	initial begin
		#(watchdog_time);
		$display("Watchdog: the tests did not finish within %0d time units.", watchdog_time);
		$display("Something failed");
		$fatal(1, "Timeout.");
	end

	initial begin
		enable = 1'b1;                                // Lookups during reset must stay invalid.
		inst1_pc = '0;
		inst1_valid = 1'b1;
		inst2_pc = '0;
		inst2_valid = 1'b1;
		branch1_pc = '0;
		branch1_taken = 1'b0;
		branch1_valid = 1'b0;
		branch2_pc = '0;
		branch2_taken = 1'b0;
		branch2_valid = 1'b0;
		do begin
			next_cycle();
		end while (reset !== 1'b0);
		lookups_after_reset();
		training_while_disabled(64'h1000);
		saturate_and_return(64'h2014);
		alternating_branch(64'h3028);
		dual_resolve(64'h403c, 64'h5004, 64'h5008);
		random_traffic();
		set_fetch('0, 1'b0, '0, 1'b0);
		set_resolve('0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
		repeat (2) next_cycle();
		$display("Everything OK");
		$finish;
	end

endmodule

//--- local_bp.f
source/isa_pkg.sv
source/predictor_pkg.sv
source/pht_if.sv
source/local_history_table.sv
source/pattern_table.sv
source/local_predictor.sv
dv/clock_gen.sv
dv/tb_local_predictor.sv

//--- Bender.yml
package:
  name: local_bp

sources:
  - source/isa_pkg.sv
  - source/predictor_pkg.sv
  - source/pht_if.sv
  - source/local_history_table.sv
  - source/pattern_table.sv
  - source/local_predictor.sv
  - target: test
    files:
      - dv/clock_gen.sv
      - dv/tb_local_predictor.sv
